// ==== common/router_defines.svh ====
// Response router sizing
// Receiver count, queue depth and packet field widths

`ifndef router_defines_svh
`define router_defines_svh

// Receivers behind the router, the last one takes forwarded traffic
`define router_num_receivers 4

// Queue entries, power of two
`define router_fifo_depth 16

// Payload word
`define router_data_width 32

// Bundle destination mask
`define router_bundle_width 4

`endif

// ==== common/packet_pkg.sv ====
// Packet types for the response router
// Field types, the stored packet and the forward receiver mask

`include "router_defines.svh"

package packet_pkg;

  typedef logic [`router_data_width-1:0] data_t;

  // One bit per receiver, also used for readies and valids
  typedef logic [`router_num_receivers-1:0] lane_mask_t;

  typedef logic [`router_bundle_width-1:0] bundle_mask_t;

  // Stored queue entry, 40 bits with the default widths
  typedef struct packed {
    data_t        data;
    lane_mask_t   lane_mask;
    bundle_mask_t bundle_mask;
  } packet_t;

  // Forwarded packets go to the last receiver only
  localparam lane_mask_t last_receiver_mask =
    lane_mask_t'(1) << (`router_num_receivers - 1);

endpackage : packet_pkg

// ==== common/route_pkg.sv ====
// Routing opcodes for the response router
// Kind of the packet popped from the queue head

package route_pkg;

  // ---------------------------------------------------------------------------
  // Route kind
  // ---------------------------------------------------------------------------
  // route_none    nothing popped this cycle
  // route_local   bundle matches, deliver on the lane mask
  // route_forward foreign bundle, deliver on the last receiver
  typedef enum logic [1:0] {
    route_none    = 2'b00,
    route_local   = 2'b01,
    route_forward = 2'b10
  } route_kind_e;

endpackage : route_pkg

// ==== response_router/response_fifo.sv ====
// Packet queue for the response router
// Synchronous first-word-fall-through circular buffer, the head entry
// is presented without a read request

`timescale 1ns/10ps

`include "router_defines.svh"

module response_fifo #(
  parameter int depth = `router_fifo_depth
) (
  input  logic                ap_clk,
  input  logic                areset_control,
  input  logic                wr_en,
  input  packet_pkg::packet_t wr_packet,
  input  logic                rd_en,
  output packet_pkg::packet_t head_packet,
  output logic                head_valid,
  output logic                full,
  output logic                empty
);

  import packet_pkg::*;

  localparam int ptr_width = $clog2(depth);

  typedef logic [ptr_width-1:0] ptr_t;
  typedef logic [ptr_width:0]   count_t;

  localparam count_t full_count = count_t'(depth);

  packet_t mem [depth];
  ptr_t    wr_ptr;
  ptr_t    rd_ptr;
  count_t  count;
  logic    do_write;
  logic    do_read;

  // Guard against overflow and underflow
  assign do_write = wr_en & ~full;
  assign do_read  = rd_en & ~empty;

  // ---------------------------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
      // Simultaneous write and pop leaves the count alone
      case ({do_write, do_read})
        2'b10:   count <= count + count_t'(1);
        2'b01:   count <= count - count_t'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge ap_clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr_packet;
    end
  end

  // ---------------------------------------------------------------------------
  // Head and flags
  // ---------------------------------------------------------------------------
  assign head_packet = mem[rd_ptr];
  assign empty       = (count == '0);
  assign full        = (count == full_count);
  assign head_valid  = ~empty;

endmodule : response_fifo

// ==== response_router/route_decode.sv ====
// Head-of-queue route decoder
// Registers receiver readies, classifies the head packet as local or
// forwarded and pops it once every addressed receiver is ready

`timescale 1ns/10ps

module route_decode #(
  parameter int own_bundle = 0
) (
  input  logic                    ap_clk,
  input  logic                    areset_control,
  input  packet_pkg::lane_mask_t  receiver_ready,
  input  packet_pkg::packet_t     head_packet,
  input  logic                    head_valid,
  output logic                    rd_en,
  output route_pkg::route_kind_e  pop_kind,
  output packet_pkg::packet_t     pop_packet
);

  import packet_pkg::*;
  import route_pkg::*;

  // One-hot of this router's bundle
  localparam bundle_mask_t own_mask = bundle_mask_t'(1) << own_bundle;

  lane_mask_t  ready_reg;
  logic        is_local;
  lane_mask_t  req_mask;
  route_kind_e head_kind;

  // Readiness is judged on last cycle's readies
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_reg <= '0;
    end else begin
      ready_reg <= receiver_ready;
    end
  end

  // ---------------------------------------------------------------------------
  // Classification and pop decision
  // ---------------------------------------------------------------------------
  assign is_local  = (head_packet.bundle_mask == own_mask);
  assign head_kind = is_local ? route_local : route_forward;

  // Forwarded traffic ignores the lane mask
  assign req_mask = is_local ? head_packet.lane_mask : last_receiver_mask;

  // Pop only when all required receivers were ready
  assign rd_en = head_valid & ((ready_reg & req_mask) == req_mask);

  // ---------------------------------------------------------------------------
  // Pop result register
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pop_kind <= route_none;
    end else if (rd_en) begin
      pop_kind <= head_kind;
    end else begin
      pop_kind <= route_none;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rd_en) begin
      pop_packet <= head_packet;
    end
  end

endmodule : route_decode

// ==== response_router/receiver_demux.sv ====
// Receiver output stage
// Turns a popped packet into per-receiver valids and registers the
// broadcast payload

`timescale 1ns/10ps

module receiver_demux (
  input  logic                     ap_clk,
  input  logic                     areset_control,
  input  route_pkg::route_kind_e   pop_kind,
  input  packet_pkg::packet_t      pop_packet,
  output packet_pkg::lane_mask_t   out_valid,
  output packet_pkg::data_t        out_data,
  output packet_pkg::lane_mask_t   out_lane_dest,
  output packet_pkg::bundle_mask_t out_bundle_dest
);

  import packet_pkg::*;
  import route_pkg::*;

  lane_mask_t valid_next;

  // Valid mask per route kind
  always_comb begin
    case (pop_kind)
      route_local:   valid_next = pop_packet.lane_mask;
      route_forward: valid_next = last_receiver_mask;
      default:       valid_next = '0;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Output registers
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= '0;
    end else begin
      out_valid <= valid_next;
    end
  end

  // Payload is shared by all receivers
  always_ff @(posedge ap_clk) begin
    out_data        <= pop_packet.data;
    out_lane_dest   <= pop_packet.lane_mask;
    out_bundle_dest <= pop_packet.bundle_mask;
  end

endmodule : receiver_demux

// ==== response_router/response_router.sv ====
// Response router top level
// Registers incoming packets, drops packets with no destination,
// queues the rest and delivers them to the addressed receivers

`timescale 1ns/10ps

`include "router_defines.svh"

module response_router #(
  parameter int own_bundle = 0
) (
  input  logic                    ap_clk,
  input  logic                    areset_control,
  input  logic                    in_valid,
  input  packet_pkg::data_t        in_data,
  input  packet_pkg::lane_mask_t   in_lane_dest,
  input  packet_pkg::bundle_mask_t in_bundle_dest,
  input  packet_pkg::lane_mask_t   receiver_ready,
  output packet_pkg::lane_mask_t   out_valid,
  output packet_pkg::data_t        out_data,
  output packet_pkg::lane_mask_t   out_lane_dest,
  output packet_pkg::bundle_mask_t out_bundle_dest,
  output logic                    fifo_full,
  output logic                    fifo_empty
);

  import packet_pkg::*;
  import route_pkg::*;

  logic        in_valid_reg;
  packet_t     in_packet_reg;
  logic        has_dest;
  logic        wr_en;
  packet_t     head_packet;
  logic        head_valid;
  logic        rd_en;
  route_kind_e pop_kind;
  packet_t     pop_packet;

  // ---------------------------------------------------------------------------
  // Input register
  // ---------------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_valid_reg <= 1'b0;
    end else begin
      in_valid_reg <= in_valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_packet_reg.data        <= in_data;
    in_packet_reg.lane_mask   <= in_lane_dest;
    in_packet_reg.bundle_mask <= in_bundle_dest;
  end

  // Both masks zero means no destination at all
  assign has_dest = (|in_packet_reg.lane_mask) | (|in_packet_reg.bundle_mask);

  // Writes into a full queue are lost
  assign wr_en = in_valid_reg & has_dest & ~fifo_full;

  // ---------------------------------------------------------------------------
  // Queue, decoder and output stage
  // ---------------------------------------------------------------------------
  response_fifo #(
    .depth(`router_fifo_depth)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .wr_en         (wr_en),
    .wr_packet     (in_packet_reg),
    .rd_en         (rd_en),
    .head_packet   (head_packet),
    .head_valid    (head_valid),
    .full          (fifo_full),
    .empty         (fifo_empty)
  );

  route_decode #(
    .own_bundle(own_bundle)
  ) u_decode (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .receiver_ready(receiver_ready),
    .head_packet   (head_packet),
    .head_valid    (head_valid),
    .rd_en         (rd_en),
    .pop_kind      (pop_kind),
    .pop_packet    (pop_packet)
  );

  receiver_demux u_demux (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .pop_kind       (pop_kind),
    .pop_packet     (pop_packet),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_lane_dest  (out_lane_dest),
    .out_bundle_dest(out_bundle_dest)
  );

endmodule : response_router

// ==== sim/response_router_props.sv ====
// Port properties of the response router
// Queue flags, valids after reset and delivery of forwarded packets

`timescale 1ns/10ps

module response_router_props #(
  parameter int own_bundle = 0
) (
  input logic                     ap_clk,
  input logic                     areset_control,
  input packet_pkg::lane_mask_t   out_valid,
  input packet_pkg::bundle_mask_t out_bundle_dest,
  input logic                     fifo_full,
  input logic                     fifo_empty
);

  import packet_pkg::*;

  localparam bundle_mask_t own_mask = bundle_mask_t'(1) << own_bundle;

  // Full never together with empty and never straight after an empty cycle
  flags_exclusive: assert property (
    @(posedge ap_clk) disable iff (areset_control)
      fifo_full |-> (!fifo_empty && !$past(fifo_empty))
  ) else $error("fifo_full is high with fifo_empty high now or one cycle earlier");

  // Nothing delivered in the cycle after a reset cycle
  reset_clears_valid: assert property (
    @(posedge ap_clk) areset_control |=> (out_valid == '0)
  ) else $error("out_valid is %b right after reset", out_valid);

  // Multicast only for local packets
  multicast_is_local: assert property (
    @(posedge ap_clk) disable iff (areset_control)
      !$onehot0(out_valid) |-> (out_bundle_dest == own_mask)
  ) else $error("multicast valid %b on bundle %b", out_valid, out_bundle_dest);

endmodule : response_router_props

bind response_router response_router_props #(
  .own_bundle(own_bundle)
) u_props (
  .ap_clk         (ap_clk),
  .areset_control (areset_control),
  .out_valid      (out_valid),
  .out_bundle_dest(out_bundle_dest),
  .fifo_full      (fifo_full),
  .fifo_empty     (fifo_empty)
);

// ==== sim/tb_response_router.sv ====
// Testbench for the response router
// Table-driven local, forward and drop traffic, back-pressure up to a
// full queue, reset state and the minimum latency

`timescale 1ns/10ps

`include "router_defines.svh"

module tb_response_router;

  import packet_pkg::*;

  localparam int table_rows     = 12;
  localparam int own_bundle     = 1;
  localparam int timeout_cycles = 40 * table_rows + 200;

  // One-hot of bundle 1
  localparam bundle_mask_t own_mask     = 4'b0010;
  localparam bundle_mask_t foreign_mask = 4'b0100;
  localparam lane_mask_t   all_ready    = '1;

  logic         ap_clk;
  logic         areset_control;
  logic         in_valid;
  data_t        in_data;
  lane_mask_t   in_lane_dest;
  bundle_mask_t in_bundle_dest;
  lane_mask_t   receiver_ready;
  lane_mask_t   out_valid;
  data_t        out_data;
  lane_mask_t   out_lane_dest;
  bundle_mask_t out_bundle_dest;
  logic         fifo_full;
  logic         fifo_empty;

  // Stimulus table, expect column holds the receiver valid mask
  string        row_name   [table_rows];
  lane_mask_t   row_lane   [table_rows];
  bundle_mask_t row_bundle [table_rows];
  data_t        row_data   [table_rows];
  lane_mask_t   row_ready  [table_rows];
  lane_mask_t   row_expect [table_rows];

  // Scoreboard, in delivery order
  string        exp_name_q   [$];
  lane_mask_t   exp_valid_q  [$];
  lane_mask_t   exp_lane_q   [$];
  bundle_mask_t exp_bundle_q [$];
  data_t        exp_data_q   [$];

  integer       seed;
  int           cycle_count  = 0;
  int           checks       = 0;
  int           value_errors = 0;
  int           other_errors = 0;
  int           out_count    = 0;
  int           edges;
  int           outs_before;
  logic         seen;
  lane_mask_t   rand_lane;
  bundle_mask_t rand_bundle;
  data_t        rand_data;
  string        mon_name;

  response_router #(
    .own_bundle(own_bundle)
  ) DUT (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .in_valid       (in_valid),
    .in_data        (in_data),
    .in_lane_dest   (in_lane_dest),
    .in_bundle_dest (in_bundle_dest),
    .receiver_ready (receiver_ready),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_lane_dest  (out_lane_dest),
    .out_bundle_dest(out_bundle_dest),
    .fifo_full      (fifo_full),
    .fifo_empty     (fifo_empty)
  );

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  // Routing rule: own bundle goes on the lane mask, anything else to the last
  function automatic lane_mask_t expected_valid(lane_mask_t lane, bundle_mask_t bundle);
    if (lane == '0 && bundle == '0) begin
      return '0;
    end
    if (bundle == own_mask) begin
      return lane;
    end
    return 4'b1000;
  endfunction

  task automatic set_row(input int idx, input string name, input lane_mask_t lane,
                         input bundle_mask_t bundle, input data_t data,
                         input lane_mask_t ready, input lane_mask_t expect_mask);
    row_name[idx]   = name;
    row_lane[idx]   = lane;
    row_bundle[idx] = bundle;
    row_data[idx]   = data;
    row_ready[idx]  = ready;
    row_expect[idx] = expect_mask;
  endtask

  task automatic load_table();
    set_row(0,  "local_lane0",          4'b0001, own_mask, 32'h1000_0001, 4'b1111, 4'b0001);
    set_row(1,  "local_lane2",          4'b0100, own_mask, 32'h1000_0002, 4'b1111, 4'b0100);
    set_row(2,  "local_multicast",      4'b1011, own_mask, 32'h1000_0003, 4'b1111, 4'b1011);
    set_row(3,  "local_broadcast",      4'b1111, own_mask, 32'h1000_0004, 4'b1111, 4'b1111);
    set_row(4,  "forward_foreign",      4'b0011, 4'b0100,  32'h2000_0005, 4'b1111, 4'b1000);
    set_row(5,  "forward_zero_bundle",  4'b0110, 4'b0000,  32'h2000_0006, 4'b1111, 4'b1000);
    set_row(6,  "drop_both_zero",       4'b0000, 4'b0000,  32'h3000_0007, 4'b1111, 4'b0000);
    set_row(7,  "after_drop",           4'b0010, own_mask, 32'h1000_0008, 4'b1111, 4'b0010);
    set_row(8,  "forward_multi_bundle", 4'b0001, 4'b0011,  32'h2000_0009, 4'b1111, 4'b1000);
    set_row(9,  "local_partial_ready",  4'b0011, own_mask, 32'h1000_000a, 4'b0111, 4'b0011);
    set_row(10, "forward_lane_ignored", 4'b1111, 4'b1000,  32'h2000_000b, 4'b1000, 4'b1000);
    set_row(11, "drop_second",          4'b0000, 4'b0000,  32'h3000_000c, 4'b1111, 4'b0000);
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      value_errors++;
    end
  endtask

  task automatic drive_packet(input lane_mask_t lane, input bundle_mask_t bundle,
                              input data_t data);
    in_valid       <= 1'b1;
    in_lane_dest   <= lane;
    in_bundle_dest <= bundle;
    in_data        <= data;
  endtask

  // Dropped packets leave nothing to wait for
  task automatic expect_packet(input string name, input lane_mask_t valid,
                               input lane_mask_t lane, input bundle_mask_t bundle,
                               input data_t data);
    if (valid != '0) begin
      exp_name_q.push_back(name);
      exp_valid_q.push_back(valid);
      exp_lane_q.push_back(lane);
      exp_bundle_q.push_back(bundle);
      exp_data_q.push_back(data);
    end
  endtask

  task automatic wait_for_drain();
    while (exp_valid_q.size() != 0) begin
      @(posedge ap_clk);
    end
    // A few idle cycles to catch stray outputs
    repeat (6) @(posedge ap_clk);
  endtask

  // ---------------------------------------------------------------------------
  // Output monitor and timeout
  // ---------------------------------------------------------------------------
  always @(negedge ap_clk) begin
    if (!areset_control && out_valid != '0) begin
      out_count++;
      assert (exp_valid_q.size() != 0) else begin
        $display("Error: receivers %b got a packet that was never sent to them", out_valid);
        other_errors++;
      end
      if (exp_valid_q.size() != 0) begin
        mon_name = exp_name_q.pop_front();
        compare_value({mon_name, " valid"}, 32'(exp_valid_q.pop_front()), 32'(out_valid));
        compare_value({mon_name, " lane_dest"}, 32'(exp_lane_q.pop_front()),
                      32'(out_lane_dest));
        compare_value({mon_name, " bundle_dest"}, 32'(exp_bundle_q.pop_front()),
                      32'(out_bundle_dest));
        compare_value({mon_name, " data"}, exp_data_q.pop_front(), out_data);
      end
    end
  end

  always @(posedge ap_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Error: timed out after %0d cycles with %0d packets still expected",
               cycle_count, exp_valid_q.size());
      $display("TEST FAIL");
      $finish;
    end
  end

  // ---------------------------------------------------------------------------
  // Test sequence
  // ---------------------------------------------------------------------------
  initial begin
    seed = 18110;
    areset_control <= 1'b1;
    in_valid       <= 1'b0;
    in_data        <= '0;
    in_lane_dest   <= '0;
    in_bundle_dest <= '0;
    receiver_ready <= all_ready;
    load_table();
    repeat (10) @(posedge ap_clk);
    areset_control <= 1'b0;

    @(negedge ap_clk);
    compare_value("reset_out_valid", 32'(0), 32'(out_valid));
    compare_value("reset_fifo_empty", 32'(1), 32'(fifo_empty));
    compare_value("reset_fifo_full", 32'(0), 32'(fifo_full));

    // Latency floor, edges counted from the driving edge
    @(posedge ap_clk);
    drive_packet(4'b0001, own_mask, 32'ha5a5_0001);
    expect_packet("latency_floor", 4'b0001, 4'b0001, own_mask, 32'ha5a5_0001);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < 12) begin
      @(posedge ap_clk);
      edges++;
      if (edges == 1) begin
        in_valid <= 1'b0;
      end
      @(negedge ap_clk);
      seen = (out_valid != '0);
    end
    compare_value("latency_floor cycles", 32'd4, 32'(edges));
    wait_for_drain();

    // Table traffic, one row per cycle
    for (int i = 0; i < table_rows; i++) begin
      @(posedge ap_clk);
      drive_packet(row_lane[i], row_bundle[i], row_data[i]);
      receiver_ready <= row_ready[i];
      expect_packet(row_name[i], row_expect[i], row_lane[i], row_bundle[i], row_data[i]);
    end
    @(posedge ap_clk);
    in_valid       <= 1'b0;
    receiver_ready <= all_ready;
    wait_for_drain();

    // Back-pressure: no receiver ready until the queue is full
    @(posedge ap_clk);
    receiver_ready <= '0;
    repeat (2) @(posedge ap_clk);
    outs_before = out_count;
    for (int k = 0; k < `router_fifo_depth; k++) begin
      rand_lane = lane_mask_t'($random(seed));
      if (rand_lane == '0) begin
        rand_lane = 4'b0001;
      end
      rand_bundle = (k % 2 == 0) ? own_mask : foreign_mask;
      rand_data   = data_t'($random(seed));
      @(posedge ap_clk);
      drive_packet(rand_lane, rand_bundle, rand_data);
      expect_packet($sformatf("stall_%0d", k), expected_valid(rand_lane, rand_bundle),
                    rand_lane, rand_bundle, rand_data);
    end
    @(posedge ap_clk);
    in_valid <= 1'b0;
    repeat (3) @(posedge ap_clk);
    @(negedge ap_clk);
    compare_value("stall_fifo_full", 32'(1), 32'(fifo_full));
    assert (out_count == outs_before) else begin
      $display("Error: a packet came out while no receiver was ready");
      other_errors++;
    end
    @(posedge ap_clk);
    receiver_ready <= all_ready;
    wait_for_drain();

    $display("Summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_response_router

// ==== response_router.f ====
+incdir+common
common/packet_pkg.sv
common/route_pkg.sv
response_router/response_fifo.sv
response_router/route_decode.sv
response_router/receiver_demux.sv
response_router/response_router.sv
sim/response_router_props.sv
sim/tb_response_router.sv

// ==== Makefile ====
# Verilator build and run for the response router

VERILATOR ?= verilator
TOP       ?= tb_response_router
FILELIST  ?= response_router.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= TEST FAIL
PASS_MSG  ?= TEST PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

SOURCES := $(wildcard common/*.sv common/*.svh response_router/*.sv sim/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended early, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
